// File: hdl/enigma_pkg.sv
package enigma_pkg;

	localparam int SYM_W       = 6;
	localparam int TABLE_DEPTH = 64;
	localparam int IDX_W       = 8;

	typedef logic [SYM_W-1:0] symbol_t; // one symbol or one table entry
	typedef logic [IDX_W-1:0] load_idx_t; // rotor code in 7:6, entry in 5:0
	typedef logic [1:0]       sel_t;

	// new C entry i takes permuted entry C_SHUFFLE[i]
	localparam symbol_t C_SHUFFLE [0:TABLE_DEPTH-1] = '{
		6'd41, 6'd56, 6'd61, 6'd29, 6'd0,  6'd26, 6'd28, 6'd63,
		6'd34, 6'd19, 6'd36, 6'd46, 6'd23, 6'd54, 6'd44, 6'd7,
		6'd43, 6'd1,  6'd42, 6'd5,  6'd40, 6'd22, 6'd6,  6'd33,
		6'd21, 6'd58, 6'd13, 6'd51, 6'd53, 6'd24, 6'd37, 6'd32,
		6'd31, 6'd11, 6'd47, 6'd25, 6'd48, 6'd2,  6'd10, 6'd9,
		6'd4,  6'd52, 6'd55, 6'd17, 6'd8,  6'd62, 6'd16, 6'd50,
		6'd38, 6'd14, 6'd30, 6'd27, 6'd57, 6'd18, 6'd60, 6'd15,
		6'd49, 6'd59, 6'd20, 6'd12, 6'd39, 6'd3,  6'd35, 6'd45
	};

endpackage

// File: hdl/enigma_ctrl_pkg.sv
package enigma_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LOAD  = 2'd1,
		READY = 2'd2
	} ctrl_state_t;

	// rotor codes in load_idx[7:6], code 3 selects nothing
	localparam logic [1:0] ROT_A = 2'd0;
	localparam logic [1:0] ROT_B = 2'd1;
	localparam logic [1:0] ROT_C = 2'd2;

endpackage

// File: hdl/rotor_if.sv
`timescale 1ns/1ns

interface rotor_if;

	enigma_pkg::symbol_t fwd_in;
	enigma_pkg::symbol_t fwd_out; // table[fwd_in]
	enigma_pkg::symbol_t inv_in;
	enigma_pkg::symbol_t inv_out; // index whose entry equals inv_in

	logic                we;
	enigma_pkg::symbol_t waddr;
	enigma_pkg::symbol_t wdata;

	logic                step; // one strobe per processed symbol

	modport user (
		output fwd_in,
		output inv_in,
		output we,
		output waddr,
		output wdata,
		output step,
		input  fwd_out,
		input  inv_out
	);

	modport rotor (
		input  fwd_in,
		input  inv_in,
		input  we,
		input  waddr,
		input  wdata,
		input  step,
		output fwd_out,
		output inv_out
	);

endinterface

// File: hdl/enigma_ctrl.sv
`timescale 1ns/1ns

module enigma_ctrl (
	input  logic clk,
	input  logic srstn,
	input  logic load_i,
	output logic load_en_o,
	output logic run_o
);

	enigma_ctrl_pkg::ctrl_state_t state, state_nx;

	always_ff @(posedge clk) begin
		if (!srstn) begin
			state <= enigma_ctrl_pkg::IDLE;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			enigma_ctrl_pkg::IDLE: begin
				if (load_i)
					state_nx = enigma_ctrl_pkg::LOAD;
			end
			enigma_ctrl_pkg::LOAD: begin
				if (!load_i)
					state_nx = enigma_ctrl_pkg::READY; // load fell, tables done
			end
			enigma_ctrl_pkg::READY: begin
				state_nx = enigma_ctrl_pkg::READY; // only reset leaves
			end
			default: begin
				state_nx = enigma_ctrl_pkg::IDLE;
			end
		endcase
	end

	// writes are accepted in IDLE too, so the first loaded entry is not lost
	assign load_en_o = (state == enigma_ctrl_pkg::IDLE) || (state == enigma_ctrl_pkg::LOAD);
	assign run_o     = (state == enigma_ctrl_pkg::READY);

endmodule

// File: hdl/rotor_shift.sv
`timescale 1ns/1ns

module rotor_shift #(
	parameter int STEP_EVERY = 1
) (
	input  logic clk,
	input  logic srstn,
	rotor_if.rotor rot
);

	localparam int CNT_W = (STEP_EVERY > 1) ? $clog2(STEP_EVERY) : 1;

	enigma_pkg::symbol_t tbl [0:enigma_pkg::TABLE_DEPTH-1];

	logic [CNT_W-1:0] step_cnt;
	logic             rotate;

	assign rotate = rot.step && (step_cnt == CNT_W'(STEP_EVERY - 1));

	// symbol divider, 1 for A and 2 for B
	always_ff @(posedge clk) begin
		if (!srstn) begin
			step_cnt <= '0;
		end else if (rot.step) begin
			if (rotate)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rot.we) begin
			tbl[rot.waddr] <= rot.wdata;
		end else if (rotate) begin
			// entry j moves to j+1, 63 wraps to 0
			for (int i = 0; i < enigma_pkg::TABLE_DEPTH; i++) begin
				tbl[(i + 1) % enigma_pkg::TABLE_DEPTH] <= tbl[i];
			end
		end
	end

	assign rot.fwd_out = tbl[rot.fwd_in];

	always_comb begin
		rot.inv_out = '0;
		for (int i = 0; i < enigma_pkg::TABLE_DEPTH; i++) begin
			if (tbl[i] == rot.inv_in)
				rot.inv_out = enigma_pkg::symbol_t'(i); // tables are permutations
		end
	end

endmodule

// File: hdl/rotor_perm.sv
`timescale 1ns/1ns

module rotor_perm (
	input  logic             clk,
	input  enigma_pkg::sel_t sel_i,
	rotor_if.rotor           rot
);

	enigma_pkg::symbol_t tbl  [0:enigma_pkg::TABLE_DEPTH-1];
	enigma_pkg::symbol_t perm [0:enigma_pkg::TABLE_DEPTH-1];
	enigma_pkg::symbol_t tbl_nx [0:enigma_pkg::TABLE_DEPTH-1];
	enigma_pkg::symbol_t grp_mask;

	// 0 keep, 1 swap neighbours, 2 swap pairs, 3 reverse
	// each case is an xor of the low two index bits
	assign grp_mask = {4'b0000, sel_i};

	always_comb begin
		for (int i = 0; i < enigma_pkg::TABLE_DEPTH; i++) begin
			perm[i] = tbl[enigma_pkg::symbol_t'(i) ^ grp_mask];
		end
	end

	always_comb begin
		for (int i = 0; i < enigma_pkg::TABLE_DEPTH; i++) begin
			tbl_nx[i] = perm[enigma_pkg::C_SHUFFLE[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (rot.we) begin
			tbl[rot.waddr] <= rot.wdata;
		end else if (rot.step) begin
			for (int i = 0; i < enigma_pkg::TABLE_DEPTH; i++) begin
				tbl[i] <= tbl_nx[i];
			end
		end
	end

	assign rot.fwd_out = tbl[rot.fwd_in];

	always_comb begin
		rot.inv_out = '0;
		for (int i = 0; i < enigma_pkg::TABLE_DEPTH; i++) begin
			if (tbl[i] == rot.inv_in)
				rot.inv_out = enigma_pkg::symbol_t'(i);
		end
	end

endmodule

// File: hdl/enigma_datapath.sv
`timescale 1ns/1ns

module enigma_datapath (
	input  logic                  clk,
	input  logic                  srstn,
	input  logic                  load_en_i,
	input  logic                  run_i,
	input  logic                  load_i,
	input  logic                  encrypt_i,
	input  logic                  crypt_mode_i,
	input  enigma_pkg::load_idx_t load_idx_i,
	input  enigma_pkg::symbol_t   code_in_i,
	rotor_if.user                 rot_a,
	rotor_if.user                 rot_b,
	rotor_if.user                 rot_c,
	output enigma_pkg::sel_t      sel_o,
	output enigma_pkg::symbol_t   code_out_o,
	output logic                  code_valid_o
);

	logic                wr;
	logic [1:0]          wr_rot;
	logic                accept;
	enigma_pkg::symbol_t refl;

	assign wr     = load_en_i && load_i;
	assign wr_rot = load_idx_i[7:6];
	assign accept = run_i && encrypt_i;

	assign rot_a.we = wr && (wr_rot == enigma_ctrl_pkg::ROT_A);
	assign rot_b.we = wr && (wr_rot == enigma_ctrl_pkg::ROT_B);
	assign rot_c.we = wr && (wr_rot == enigma_ctrl_pkg::ROT_C);

	assign rot_a.waddr = load_idx_i[5:0];
	assign rot_b.waddr = load_idx_i[5:0];
	assign rot_c.waddr = load_idx_i[5:0];
	assign rot_a.wdata = code_in_i;
	assign rot_b.wdata = code_in_i;
	assign rot_c.wdata = code_in_i;

	// forward A -> B -> C
	assign rot_a.fwd_in = code_in_i;
	assign rot_b.fwd_in = rot_a.fwd_out;
	assign rot_c.fwd_in = rot_b.fwd_out;

	assign refl = ~rot_c.fwd_out; // 63 - x

	// back C -> B -> A
	assign rot_c.inv_in = refl;
	assign rot_b.inv_in = rot_c.inv_out;
	assign rot_a.inv_in = rot_b.inv_out;

	// decrypt sees the swapped pair, so C permutes the same way both ways
	assign sel_o = crypt_mode_i ? refl[1:0] : rot_c.fwd_out[1:0];

	assign rot_a.step = accept;
	assign rot_b.step = accept;
	assign rot_c.step = accept;

	always_ff @(posedge clk) begin
		if (!srstn) begin
			code_valid_o <= 1'b0;
		end else begin
			code_valid_o <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			code_out_o <= rot_a.inv_out; // held while valid low
	end

endmodule

// File: hdl/enigma_top.sv
`timescale 1ns/1ns

module enigma_top (
	input  logic                         clk,
	input  logic                         srstn,
	input  logic                         load_i,
	input  logic                         encrypt_i,
	input  logic                         crypt_mode_i,
	input  logic [enigma_pkg::IDX_W-1:0] load_idx_i,
	input  logic [enigma_pkg::SYM_W-1:0] code_in_i,
	output logic [enigma_pkg::SYM_W-1:0] code_out_o,
	output logic                         code_valid_o
);

	logic             load_en;
	logic             run;
	enigma_pkg::sel_t sel;

	rotor_if rot_a_if ();
	rotor_if rot_b_if ();
	rotor_if rot_c_if ();

	enigma_ctrl i_enigma_ctrl (
		.clk       (clk),
		.srstn     (srstn),
		.load_i    (load_i),
		.load_en_o (load_en),
		.run_o     (run)
	);

	enigma_datapath i_enigma_datapath (
		.clk          (clk),
		.srstn        (srstn),
		.load_en_i    (load_en),
		.run_i        (run),
		.load_i       (load_i),
		.encrypt_i    (encrypt_i),
		.crypt_mode_i (crypt_mode_i),
		.load_idx_i   (load_idx_i),
		.code_in_i    (code_in_i),
		.rot_a        (rot_a_if),
		.rot_b        (rot_b_if),
		.rot_c        (rot_c_if),
		.sel_o        (sel),
		.code_out_o   (code_out_o),
		.code_valid_o (code_valid_o)
	);

	// A steps every symbol
	rotor_shift #(
		.STEP_EVERY (1)
	) i_rotor_a (
		.clk   (clk),
		.srstn (srstn),
		.rot   (rot_a_if)
	);

	// B every second symbol
	rotor_shift #(
		.STEP_EVERY (2)
	) i_rotor_b (
		.clk   (clk),
		.srstn (srstn),
		.rot   (rot_b_if)
	);

	rotor_perm i_rotor_c (
		.clk   (clk),
		.sel_i (sel),
		.rot   (rot_c_if)
	);

endmodule

// File: testbench/enigma_asserts.sv
`timescale 1ns/1ns

module enigma_asserts (
	input logic                         clk,
	input logic                         srstn,
	input logic                         encrypt_i,
	input logic [enigma_pkg::SYM_W-1:0] code_out_i,
	input logic                         code_valid_i
);

	int err_cnt = 0;

	valid_after_reset: assert property (@(posedge clk) !srstn |=> !code_valid_i)
		else begin
			err_cnt = err_cnt + 1;
			$error("code_valid_o high in the cycle after reset");
		end

	// one cycle from accepted symbol to output
	valid_needs_encrypt: assert property (@(posedge clk) disable iff (!srstn)
		code_valid_i |-> $past(encrypt_i))
		else begin
			err_cnt = err_cnt + 1;
			$error("code_valid_o high without encrypt_i one cycle earlier");
		end

	out_held: assert property (@(posedge clk) disable iff (!srstn)
		!code_valid_i |-> $stable(code_out_i))
		else begin
			err_cnt = err_cnt + 1;
			$error("code_out_o changed while code_valid_o was low");
		end

endmodule

bind enigma_top enigma_asserts i_enigma_asserts (
	.clk          (clk),
	.srstn        (srstn),
	.encrypt_i    (encrypt_i),
	.code_out_i   (code_out_o),
	.code_valid_i (code_valid_o)
);

// File: testbench/enigma_tb.sv
`timescale 1ns/1ns

module enigma_tb;

	localparam int SEED           = 71603;
	localparam int TIMEOUT_CYCLES = 2000; // two passes take about 450
	localparam int N_ROWS         = 20;

	// {encrypt, symbol}, encrypt low marks a gap
	localparam logic [6:0] STIM [N_ROWS] = '{
		{1'b1, 6'd12}, {1'b1, 6'd45}, {1'b1, 6'd0},  {1'b1, 6'd63},
		{1'b0, 6'd7},  {1'b1, 6'd7},  {1'b1, 6'd33}, {1'b0, 6'd21},
		{1'b0, 6'd50}, {1'b1, 6'd21}, {1'b1, 6'd12}, {1'b1, 6'd12},
		{1'b1, 6'd58}, {1'b0, 6'd3},  {1'b1, 6'd3},  {1'b1, 6'd40},
		{1'b1, 6'd19}, {1'b1, 6'd63}, {1'b1, 6'd1},  {1'b1, 6'd30}
	};

	logic       clk;
	logic       srstn;
	logic       load;
	logic       encrypt;
	logic       crypt_mode;
	logic [7:0] load_idx;
	logic [5:0] code_in;
	logic [5:0] code_out;
	logic       code_valid;

	enigma_pkg::symbol_t init_tbl [3][64]; // tables loaded into the DUT
	enigma_pkg::symbol_t mdl_tbl  [3][64]; // model copy, stepped per symbol
	enigma_pkg::symbol_t cipher   [N_ROWS];
	enigma_pkg::symbol_t expected [N_ROWS];
	logic                b_odd;
	int                  cycle_cnt = 0;

	enigma_top i_enigma_top (
		.clk          (clk),
		.srstn        (srstn),
		.load_i       (load),
		.encrypt_i    (encrypt),
		.crypt_mode_i (crypt_mode),
		.load_idx_i   (load_idx),
		.code_in_i    (code_in),
		.code_out_o   (code_out),
		.code_valid_o (code_valid)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout: run still going after %0d cycles", cycle_cnt));
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic value_error(input string what);
		abort_run($sformatf("Fail at %0t ns: %s", $time, what));
	endtask

	task automatic build_tables();
		int                  j;
		enigma_pkg::symbol_t tmp;
		for (int r = 0; r < 3; r++) begin
			for (int e = 0; e < 64; e++)
				init_tbl[r][e] = 6'(e);
			// fisher-yates
			for (int i = 63; i > 0; i--) begin
				j = $urandom_range(i, 0);
				tmp = init_tbl[r][i];
				init_tbl[r][i] = init_tbl[r][j];
				init_tbl[r][j] = tmp;
			end
		end
	endtask

	function automatic enigma_pkg::symbol_t inverse_lookup(input int r,
			input enigma_pkg::symbol_t v);
		enigma_pkg::symbol_t idx;
		idx = '0;
		for (int k = 0; k < 64; k++) begin
			if (mdl_tbl[r][k] == v)
				idx = 6'(k);
		end
		return idx;
	endfunction

	task automatic rotate_by_one(input int r);
		enigma_pkg::symbol_t last;
		last = mdl_tbl[r][63];
		for (int j = 63; j > 0; j--)
			mdl_tbl[r][j] = mdl_tbl[r][j-1];
		mdl_tbl[r][0] = last;
	endtask

	task automatic model_symbol(input enigma_pkg::symbol_t sym, input logic decrypt,
			output enigma_pkg::symbol_t res);
		enigma_pkg::symbol_t fc;
		enigma_pkg::symbol_t rf;
		logic [1:0]          sel;
		enigma_pkg::symbol_t old_t [64];
		enigma_pkg::symbol_t grp [64];
		int                  src;
		fc = mdl_tbl[2][mdl_tbl[1][mdl_tbl[0][sym]]];
		rf = 6'd63 - fc;
		res = inverse_lookup(0, inverse_lookup(1, inverse_lookup(2, rf)));
		sel = decrypt ? rf[1:0] : fc[1:0];
		rotate_by_one(0);
		if (b_odd)
			rotate_by_one(1); // B on every second symbol
		b_odd = !b_odd;
		for (int i = 0; i < 64; i++)
			old_t[i] = mdl_tbl[2][i];
		for (int i = 0; i < 64; i++) begin
			case (sel)
				2'd0: src = i;
				2'd1: src = (i % 2 == 0) ? i + 1 : i - 1; // neighbours
				2'd2: src = (i % 4 < 2) ? i + 2 : i - 2; // pairs
				default: src = (i - i % 4) + 3 - i % 4; // reversed group
			endcase
			grp[i] = old_t[src];
		end
		for (int i = 0; i < 64; i++)
			mdl_tbl[2][i] = grp[enigma_pkg::C_SHUFFLE[i]];
	endtask

	task automatic build_expected(input logic decrypt);
		enigma_pkg::symbol_t res;
		for (int r = 0; r < 3; r++) begin
			for (int e = 0; e < 64; e++)
				mdl_tbl[r][e] = init_tbl[r][e];
		end
		b_odd = 1'b0;
		for (int r = 0; r < N_ROWS; r++) begin
			if (!STIM[r][6]) begin
				if (!decrypt)
					cipher[r] = STIM[r][5:0];
				expected[r] = STIM[r][5:0];
			end else if (!decrypt) begin
				model_symbol(STIM[r][5:0], 1'b0, res);
				cipher[r] = res;
				expected[r] = res;
			end else begin
				model_symbol(cipher[r], 1'b1, res);
				assert (res == STIM[r][5:0])
					else abort_run($sformatf("reference model does not decrypt row %0d", r));
				expected[r] = STIM[r][5:0];
			end
		end
	endtask

	task automatic check_no_valid();
		assert (code_valid === 1'b0)
			else value_error("code_valid_o high before the first encrypt");
	endtask

	task automatic check_row(input int r);
		if (STIM[r][6]) begin
			assert (code_valid === 1'b1)
				else value_error($sformatf("row %0d left code_valid_o low", r));
			assert (code_out === expected[r])
				else value_error($sformatf("row %0d code_out_o %0d, expected %0d",
					r, code_out, expected[r]));
		end else begin
			assert (code_valid === 1'b0)
				else value_error($sformatf("row %0d is a gap but code_valid_o is high", r));
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		srstn   = 1'b0;
		load    = 1'b0;
		encrypt = 1'b0;
		repeat (2) @(negedge clk);
		srstn = 1'b1;
	endtask

	task automatic load_tables();
		for (int r = 0; r < 3; r++) begin
			for (int e = 0; e < 64; e++) begin
				@(negedge clk);
				check_no_valid();
				load     = 1'b1;
				load_idx = {2'(r), 6'(e)};
				code_in  = init_tbl[r][e];
			end
		end
		@(negedge clk);
		check_no_valid();
		load_idx = {2'b11, 6'd5}; // no rotor behind code 3
		code_in  = ~init_tbl[0][5];
		@(negedge clk);
		check_no_valid();
		load = 1'b0; // READY from the next edge
		@(negedge clk);
		check_no_valid();
		load     = 1'b1;
		load_idx = {2'b00, 6'd12}; // row 0 reads this A entry
		code_in  = ~init_tbl[0][12];
		@(negedge clk);
		check_no_valid();
		load = 1'b0;
	endtask

	task automatic apply_rows(input logic decrypt);
		for (int r = 0; r < N_ROWS; r++) begin
			@(negedge clk);
			if (r > 0)
				check_row(r - 1); // result of the previous row
			crypt_mode = decrypt;
			encrypt    = STIM[r][6];
			code_in    = decrypt ? cipher[r] : STIM[r][5:0];
		end
		@(negedge clk);
		check_row(N_ROWS - 1);
		encrypt = 1'b0;
	endtask

	initial begin
		clk        = 1'b0;
		srstn      = 1'b0;
		load       = 1'b0;
		encrypt    = 1'b0;
		crypt_mode = 1'b0;
		load_idx   = '0;
		code_in    = '0;
		b_odd      = 1'b0;
		void'($urandom(SEED));
		build_tables();

		apply_reset();
		load_tables();
		build_expected(1'b0);
		apply_rows(1'b0);

		// same tables again, ciphertext goes back in
		apply_reset();
		load_tables();
		build_expected(1'b1);
		apply_rows(1'b1);

		@(negedge clk);
		if (i_enigma_top.i_enigma_asserts.err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("%0d concurrent assertion failures", i_enigma_top.i_enigma_asserts.err_cnt);
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: vlog.f
hdl/enigma_pkg.sv
hdl/enigma_ctrl_pkg.sv
hdl/rotor_if.sv
hdl/enigma_ctrl.sv
hdl/rotor_shift.sv
hdl/rotor_perm.sv
hdl/enigma_datapath.sv
hdl/enigma_top.sv
testbench/enigma_asserts.sv
testbench/enigma_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, then decide pass or fail from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module enigma_tb -f vlog.f -o enigma_sim &&
	./obj_dir/enigma_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
